// ==== icache_pkg.sv ====
package icache_pkg;

    // cache geometry
    localparam int IC_SETS    = 64;
    localparam int IC_INDEX_W = 6;
    localparam int IC_TAG_W   = 55;

    // replacement age counters, saturating
    localparam int IC_AGE_W   = 3;

    // one fetched instruction
    typedef logic [31:0] icache_inst_t;

    // fetch address split
    // tag | index | half | byte offset
    typedef struct packed {
        logic [IC_TAG_W-1:0]   tag;
        logic [IC_INDEX_W-1:0] index;
        logic                  half;
        logic [1:0]            offset;
    } icache_addr_t;

    // refill word from memory
    // raw view for storage, inst view for picking a half
    typedef union packed {
        logic [63:0]           raw;
        icache_inst_t [1:0]    inst;
    } icache_line_u;

    // controller states, one-hot
    typedef enum logic [3:0] {
        IDLE   = 4'b0001,
        LOOKUP = 4'b0010,
        REFILL = 4'b0100,
        RESP   = 4'b1000
    } icache_state_e;

endpackage

// ==== icache_tag_ram.sv ====
`timescale 1ns/100ps

module icache_tag_ram (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [icache_pkg::IC_INDEX_W-1:0] i_index,
    input  logic                              i_we,
    input  logic [icache_pkg::IC_TAG_W-1:0]   i_tag,
    output logic [icache_pkg::IC_TAG_W-1:0]   o_tag,
    output logic                              o_valid
);
    import icache_pkg::*;

    logic [IC_TAG_W-1:0] tag_mem [IC_SETS];
    logic [IC_SETS-1:0]  valid_q;

    // tag storage, read is registered
    always_ff @(posedge clk) begin
        if (i_we) begin
            tag_mem[i_index] <= i_tag;
        end
        o_tag <= tag_mem[i_index];
    end

    // valid bits, all cleared on reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (i_we) begin
            valid_q[i_index] <= 1'b1;
        end
    end

    // registered valid read, follows the tag read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= valid_q[i_index];
        end
    end

endmodule

// ==== icache_data_ram.sv ====
`timescale 1ns/100ps

module icache_data_ram (
    input  logic                              clk,
    input  logic [icache_pkg::IC_INDEX_W-1:0] i_index,
    input  logic                              i_we,
    input  icache_pkg::icache_line_u          i_line,
    output icache_pkg::icache_line_u          o_line
);
    import icache_pkg::*;

    icache_line_u line_mem [IC_SETS];

    // one line per set
    // read returns the old line when written on the same edge
    always_ff @(posedge clk) begin
        if (i_we) begin
            line_mem[i_index] <= i_line;
        end
        o_line <= line_mem[i_index];
    end

endmodule

// ==== icache_lru.sv ====
`timescale 1ns/100ps

module icache_lru (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_access,
    input  logic [icache_pkg::IC_INDEX_W-1:0] i_index,
    input  logic                              i_way,
    input  logic                              i_valid0,
    input  logic                              i_valid1,
    output logic                              o_victim
);
    import icache_pkg::*;

    logic [IC_AGE_W-1:0] age0 [IC_SETS];
    logic [IC_AGE_W-1:0] age1 [IC_SETS];

    // used way goes to zero, the other one ages
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < IC_SETS; i++) begin
                age0[i] <= '0;
                age1[i] <= '0;
            end
        end else if (i_access) begin
            if (i_way) begin
                age1[i_index] <= '0;
                if (age0[i_index] != '1) begin
                    age0[i_index] <= age0[i_index] + 1'b1;
                end
            end else begin
                age0[i_index] <= '0;
                if (age1[i_index] != '1) begin
                    age1[i_index] <= age1[i_index] + 1'b1;
                end
            end
        end
    end

    // empty way first, then the older one, ties to way 0
    always_comb begin
        if (!i_valid0) begin
            o_victim = 1'b0;
        end else if (!i_valid1) begin
            o_victim = 1'b1;
        end else begin
            o_victim = (age1[i_index] > age0[i_index]);
        end
    end

    a_way_known: assert property (@(posedge clk) disable iff (!rst)
        i_access |-> !$isunknown(i_way));

endmodule

// ==== icache_ctrl.sv ====
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    // fetch side
    input  logic                              i_inst_ena,
    input  icache_pkg::icache_addr_t          i_inst_addr,
    output icache_pkg::icache_inst_t          o_inst_data,
    output logic                              o_inst_valid,
    // memory side
    output logic                              o_mem_read_ena,
    output logic [63:0]                       o_mem_addr,
    input  icache_pkg::icache_line_u          i_mem_data,
    input  logic                              i_mem_ok,
    // tag rams
    output logic [icache_pkg::IC_INDEX_W-1:0] o_index,
    input  logic [icache_pkg::IC_TAG_W-1:0]   i_tag0,
    input  logic                              i_valid0,
    input  logic [icache_pkg::IC_TAG_W-1:0]   i_tag1,
    input  logic                              i_valid1,
    output logic                              o_tag_we0,
    output logic                              o_tag_we1,
    output logic [icache_pkg::IC_TAG_W-1:0]   o_wr_tag,
    // data rams
    input  icache_pkg::icache_line_u          i_line0,
    input  icache_pkg::icache_line_u          i_line1,
    output icache_pkg::icache_line_u          o_wr_line,
    // replacement tracker
    output logic                              o_access,
    output logic                              o_access_way,
    input  logic                              i_victim
);
    import icache_pkg::*;

    icache_state_e state_q;
    icache_state_e state_d;
    icache_addr_t  req_q;
    logic          victim_q;
    logic          hit0;
    logic          hit1;
    logic          hit;
    logic          lookup_hit;
    logic          refill_done;

    // rams read the incoming address while idle, so tags are ready in LOOKUP
    assign o_index = (state_q == IDLE) ? i_inst_addr.index : req_q.index;

    assign hit0 = i_valid0 && (i_tag0 == req_q.tag);
    assign hit1 = i_valid1 && (i_tag1 == req_q.tag);
    assign hit  = hit0 || hit1;

    assign lookup_hit  = (state_q == LOOKUP) && hit;
    assign refill_done = (state_q == REFILL) && i_mem_ok;

    // line aligned fetch address
    assign o_mem_addr = {req_q.tag, req_q.index, 3'b000};

    // refill writes go to the way picked at miss time
    assign o_tag_we0 = refill_done && !victim_q;
    assign o_tag_we1 = refill_done && victim_q;
    assign o_wr_tag  = req_q.tag;
    assign o_wr_line = i_mem_data;

    // age update on every hit and every refill
    assign o_access     = lookup_hit || refill_done;
    assign o_access_way = (state_q == LOOKUP) ? hit1 : victim_q;

    // request and victim capture
    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && i_inst_ena) begin
            req_q <= i_inst_addr;
        end
        if ((state_q == LOOKUP) && !hit) begin
            victim_q <= i_victim;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_inst_ena) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = hit ? RESP : REFILL;
            end
            REFILL: begin
                // wait as long as memory needs
                if (i_mem_ok) begin
                    state_d = RESP;
                end
            end
            RESP: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q        <= IDLE;
            o_inst_valid   <= 1'b0;
            o_inst_data    <= '0;
            o_mem_read_ena <= 1'b0;
        end else begin
            state_q      <= state_d;
            o_inst_valid <= 1'b0;
            if (lookup_hit) begin
                o_inst_valid <= 1'b1;
                o_inst_data  <= hit1 ? i_line1.inst[req_q.half] : i_line0.inst[req_q.half];
            end
            // miss, start the line fetch
            if ((state_q == LOOKUP) && !hit) begin
                o_mem_read_ena <= 1'b1;
            end
            // forward the wanted half straight from the memory word
            if (refill_done) begin
                o_mem_read_ena <= 1'b0;
                o_inst_valid   <= 1'b1;
                o_inst_data    <= i_mem_data.inst[req_q.half];
            end
        end
    end

    a_ena_in_idle: assert property (@(posedge clk) disable iff (!rst)
        i_inst_ena |-> (state_q == IDLE));

    a_read_held: assert property (@(posedge clk) disable iff (!rst)
        (o_mem_read_ena && !i_mem_ok) |=> (o_mem_read_ena && $stable(o_mem_addr)));

    a_one_hit: assert property (@(posedge clk) disable iff (!rst)
        (state_q == LOOKUP) |-> !(hit0 && hit1));

endmodule

// ==== icache_top.sv ====
`timescale 1ns/100ps

module icache_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_inst_ena,
    input  icache_pkg::icache_addr_t i_inst_addr,
    output icache_pkg::icache_inst_t o_inst_data,
    output logic                     o_inst_valid,
    output logic                     o_mem_read_ena,
    output logic [63:0]              o_mem_addr,
    input  icache_pkg::icache_line_u i_mem_data,
    input  logic                     i_mem_ok
);
    import icache_pkg::*;

    logic [IC_INDEX_W-1:0] index;
    logic [IC_TAG_W-1:0]   tag0;
    logic [IC_TAG_W-1:0]   tag1;
    logic [IC_TAG_W-1:0]   wr_tag;
    logic                  valid0;
    logic                  valid1;
    logic                  we0;
    logic                  we1;
    icache_line_u          line0;
    icache_line_u          line1;
    icache_line_u          wr_line;
    logic                  access;
    logic                  access_way;
    logic                  victim;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_inst_ena     (i_inst_ena),
        .i_inst_addr    (i_inst_addr),
        .o_inst_data    (o_inst_data),
        .o_inst_valid   (o_inst_valid),
        .o_mem_read_ena (o_mem_read_ena),
        .o_mem_addr     (o_mem_addr),
        .i_mem_data     (i_mem_data),
        .i_mem_ok       (i_mem_ok),
        .o_index        (index),
        .i_tag0         (tag0),
        .i_valid0       (valid0),
        .i_tag1         (tag1),
        .i_valid1       (valid1),
        .o_tag_we0      (we0),
        .o_tag_we1      (we1),
        .o_wr_tag       (wr_tag),
        .i_line0        (line0),
        .i_line1        (line1),
        .o_wr_line      (wr_line),
        .o_access       (access),
        .o_access_way   (access_way),
        .i_victim       (victim)
    );

    // way 0
    icache_tag_ram u_tag0 (
        .clk     (clk),
        .rst     (rst),
        .i_index (index),
        .i_we    (we0),
        .i_tag   (wr_tag),
        .o_tag   (tag0),
        .o_valid (valid0)
    );

    icache_data_ram u_data0 (
        .clk     (clk),
        .i_index (index),
        .i_we    (we0),
        .i_line  (wr_line),
        .o_line  (line0)
    );

    // way 1
    icache_tag_ram u_tag1 (
        .clk     (clk),
        .rst     (rst),
        .i_index (index),
        .i_we    (we1),
        .i_tag   (wr_tag),
        .o_tag   (tag1),
        .o_valid (valid1)
    );

    icache_data_ram u_data1 (
        .clk     (clk),
        .i_index (index),
        .i_we    (we1),
        .i_line  (wr_line),
        .o_line  (line1)
    );

    icache_lru u_lru (
        .clk      (clk),
        .rst      (rst),
        .i_access (access),
        .i_index  (index),
        .i_way    (access_way),
        .i_valid0 (valid0),
        .i_valid1 (valid1),
        .o_victim (victim)
    );

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
    output logic o_clk
);

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #2 o_clk = ~o_clk;
        end
    end

endmodule

// ==== tb_icache.sv ====
`timescale 1ns/100ps

module tb_icache;
    import icache_pkg::*;

    localparam int N_FIRST     = 8;
    localparam int N_RANDOM    = 200;
    localparam int N_REQUESTS  = 3 * N_FIRST + 16 + N_RANDOM;
    // twice 20 cycles of 4 ns per request
    localparam int WATCHDOG_NS = N_REQUESTS * 20 * 4 * 2;

    typedef struct packed {
        logic         hit;
        icache_inst_t inst;
        logic [63:0]  mem_addr;
    } fetch_exp_t;

    logic         clk;
    logic         rst;
    logic         i_inst_ena;
    icache_addr_t i_inst_addr;
    icache_inst_t o_inst_data;
    logic         o_inst_valid;
    logic         o_mem_read_ena;
    logic [63:0]  o_mem_addr;
    icache_line_u i_mem_data;
    logic         i_mem_ok;

    // reference cache state
    logic [IC_TAG_W-1:0] ref_tag [IC_SETS][2];
    logic [1:0]          ref_valid [IC_SETS];
    logic                ref_mru [IC_SETS];
    fetch_exp_t          exp_q [$];
    logic [31:0]         stim_state;

    tb_clkgen u_clkgen (.o_clk(clk));

    icache_top i_icache_top (
        .clk            (clk),
        .rst            (rst),
        .i_inst_ena     (i_inst_ena),
        .i_inst_addr    (i_inst_addr),
        .o_inst_data    (o_inst_data),
        .o_inst_valid   (o_inst_valid),
        .o_mem_read_ena (o_mem_read_ena),
        .o_mem_addr     (o_mem_addr),
        .i_mem_data     (i_mem_data),
        .i_mem_ok       (i_mem_ok)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_stim();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    function automatic logic [IC_TAG_W-1:0] random_tag();
        logic [63:0] wide;
        wide[63:32] = next_stim();
        wide[31:0]  = next_stim();
        return wide[IC_TAG_W-1:0];
    endfunction

    // memory contents are a hash of the line address
    function automatic icache_line_u line_for(input logic [63:0] line_addr);
        icache_line_u word;
        word.inst[0] = xorshift32(line_addr[31:0] ^ line_addr[63:32] ^ 32'h6eb1);
        word.inst[1] = xorshift32(word.inst[0] ^ 32'h5bd1e995);
        return word;
    endfunction

    // victim is an invalid way (way 0 first) or else the way not used last
    function automatic fetch_exp_t predict_fetch(input icache_addr_t a);
        fetch_exp_t   e;
        icache_line_u word;
        logic         way;
        e.mem_addr = a & ~64'h7;
        word       = line_for(e.mem_addr);
        e.inst     = word.inst[a.half];
        e.hit      = 1'b1;
        if (ref_valid[a.index][0] && ref_tag[a.index][0] == a.tag) begin
            way = 1'b0;
        end else if (ref_valid[a.index][1] && ref_tag[a.index][1] == a.tag) begin
            way = 1'b1;
        end else begin
            e.hit = 1'b0;
            way   = !ref_valid[a.index][0] ? 1'b0 :
                    !ref_valid[a.index][1] ? 1'b1 : !ref_mru[a.index];
            ref_valid[a.index][way] = 1'b1;
            ref_tag[a.index][way]   = a.tag;
        end
        ref_mru[a.index] = way;
        return e;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_inst(input icache_inst_t got, input icache_inst_t want);
        if (got !== want) begin
            $display("FAIL %0t o_inst_data got %h expected %h", $time, got, want);
            stop_run("wrong instruction returned");
        end
    endtask

    task automatic check_mem_addr(input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("FAIL %0t o_mem_addr got %h expected %h", $time, got, want);
            stop_run("wrong memory address");
        end
    endtask

    task automatic check_hit(input bit got, input bit want);
        if (got !== want) begin
            $display("FAIL %0t hit got %0b expected %0b", $time, got, want);
            stop_run("hit or miss differs from the reference cache");
        end
    endtask

    task automatic apply_reset();
        rst <= 1'b0;
        foreach (ref_valid[k]) begin
            ref_valid[k] = 2'b00;
            ref_mru[k]   = 1'b0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        if (o_inst_valid !== 1'b0 || o_mem_read_ena !== 1'b0) begin
            stop_run("o_inst_valid or o_mem_read_ena high after reset");
        end
        check_inst(o_inst_data, '0);
    endtask

    // drive one fetch and wait for o_inst_valid
    task automatic fetch(input icache_addr_t a, input int want);
        fetch_exp_t e;
        int         n;
        e = predict_fetch(a);
        if (want >= 0 && e.hit != want[0]) begin
            stop_run("reference cache disagrees with the directed hit pattern");
        end
        exp_q.push_back(e);
        i_inst_ena  <= 1'b1;
        i_inst_addr <= a;
        @(posedge clk);
        i_inst_ena  <= 1'b0;
        n = 0;
        while (o_inst_valid !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 30) begin
                stop_run("no o_inst_valid within 30 cycles of a fetch");
            end
        end
    endtask

    initial begin : stimulus
        icache_addr_t        first [N_FIRST];
        icache_addr_t        a;
        logic [IC_TAG_W-1:0] t [3];
        int                  order [8];
        int                  hits [8];
        logic [31:0]         r;
        stim_state  = 32'h6eb1;
        i_inst_ena  <= 1'b0;
        i_inst_addr <= '0;
        apply_reset();
        // cold fetches over eight sets
        for (int i = 0; i < N_FIRST; i++) begin
            first[i] = '{tag: random_tag(), index: 6'(i * 7), half: i[0], offset: 2'b00};
            fetch(first[i], 0);
        end
        for (int i = N_FIRST - 1; i >= 0; i--) begin
            fetch(first[i], 1);
        end
        // both halves out of one refill
        for (int i = 0; i < 4; i++) begin
            a = '{tag: random_tag(), index: 6'(50 + i), half: i[0], offset: 2'b00};
            fetch(a, 0);
            a.half = !a.half;
            fetch(a, 1);
        end
        // three tags fighting over the two ways of set 40
        foreach (t[k]) begin
            t[k] = random_tag();
        end
        order = '{0, 1, 0, 2, 0, 1, 2, 1};
        hits  = '{0, 0, 1, 0, 1, 0, 0, 1};
        for (int k = 0; k < 8; k++) begin
            a = '{tag: t[order[k]], index: 6'd40, half: k[0], offset: 2'b00};
            fetch(a, hits[k]);
        end
        // four tags over four sets give lots of conflict misses
        for (int i = 0; i < N_RANDOM; i++) begin
            r = next_stim();
            a = '{tag: IC_TAG_W'(r[1:0]), index: 6'(r[3:2]), half: r[4], offset: 2'b00};
            fetch(a, -1);
        end
        apply_reset();
        foreach (first[i]) begin
            fetch(first[i], 0);
        end
        repeat (4) @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin : compare_responses
        int         cyc;
        int         req_cyc;
        int         ok_cyc;
        logic       saw_read;
        fetch_exp_t e;
        cyc      = 0;
        req_cyc  = 0;
        ok_cyc   = 0;
        saw_read = 1'b0;
        forever begin
            @(posedge clk);
            cyc++;
            if (rst === 1'b1) begin
                if (i_inst_ena) begin
                    req_cyc  = cyc;
                    saw_read = 1'b0;
                end
                if (i_mem_ok) begin
                    ok_cyc = cyc;
                end
                if (o_mem_read_ena && !saw_read) begin
                    saw_read = 1'b1;
                    if (cyc != req_cyc + 2 || exp_q.size() == 0) begin
                        stop_run("o_mem_read_ena did not rise two cycles after a fetch");
                    end else begin
                        check_mem_addr(o_mem_addr, exp_q[0].mem_addr);
                    end
                end
                if (o_inst_valid) begin
                    if (exp_q.size() == 0) begin
                        stop_run("o_inst_valid with no fetch outstanding");
                    end else begin
                        e = exp_q.pop_front();
                        check_hit(!saw_read, e.hit);
                        check_inst(o_inst_data, e.inst);
                        if (o_mem_read_ena || cyc != (e.hit ? req_cyc + 2 : ok_cyc + 1)) begin
                            stop_run("response timing wrong for a hit or a refill");
                        end
                    end
                end
            end
        end
    end

    // memory answers a held read after 1 to 8 cycles
    initial begin : memory_model
        logic [31:0] lat_state;
        logic [63:0] held_addr;
        i_mem_ok   <= 1'b0;
        i_mem_data <= '0;
        lat_state  = xorshift32(32'h6eb1);
        forever begin
            @(posedge clk);
            if (rst === 1'b1 && o_mem_read_ena === 1'b1) begin
                held_addr = o_mem_addr;
                lat_state = xorshift32(lat_state);
                repeat (lat_state % 8) begin
                    @(posedge clk);
                    if (o_mem_read_ena !== 1'b1) begin
                        stop_run("o_mem_read_ena dropped before i_mem_ok");
                    end
                    check_mem_addr(o_mem_addr, held_addr);
                end
                i_mem_ok   <= 1'b1;
                i_mem_data <= line_for(held_addr);
                @(posedge clk);
                check_mem_addr(o_mem_addr, held_addr);
                i_mem_ok   <= 1'b0;
                i_mem_data <= '0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_run("watchdog expired before all fetches completed");
    end

endmodule

// ==== all.f ====
icache_pkg.sv
icache_tag_ram.sv
icache_data_ram.sv
icache_lru.sv
icache_ctrl.sv
icache_top.sv
tb_clkgen.sv
tb_icache.sv

// ==== Makefile ====
SOURCES = $(shell grep '\.sv$$' all.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_icache: all.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module tb_icache -f all.f

run: obj_dir/Vtb_icache
	./obj_dir/Vtb_icache | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
